// File: noc_mesh.f
src/noc_pkg.sv
src/port_arbiter.sv
src/flit_deserializer.sv
src/flit_serializer.sv
src/mesh_router.sv
src/mesh_edge_side.sv
src/noc_mesh.sv
test/noc_mesh_assert.sv
test/noc_mesh_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= noc_mesh_tb
FILELIST  ?= noc_mesh.f
OBJ_DIR   ?= obj_dir
TRACE     ?= test/noc_mesh_trace.txt
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) $(TRACE)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: test/noc_mesh_trace.txt
// in_side in_sel vc dest_x dest_y payload exit_side exit_sel group (all hex)
// Sides 0 north, 1 east, 2 south, 3 west; same group means same injection cycle
3 1 1 4 2 0123456789abcde 1 1 0
3 0 2 3 4 2a5a5a5a5a5a5a5 0 2 1
2 2 0 3 4 3c0ffee00112233 0 2 2
1 2 3 3 4 1deadbeef445566 0 2 2
0 1 3 2 0 0f0e0d0c0b0a090 2 1 3
0 0 1 1 0 155aa55aa55aa55 2 1 4
0 0 0 0 1 2468ace13579bdf 3 0 5
1 1 1 3 0 3fedcba98765432 2 2 5
2 0 2 4 3 0aaaa5555cccc33 1 2 6
3 2 3 2 4 111122223333444 0 1 6
0 1 2 4 2 0badc0de0badc0d 1 1 7
2 1 0 4 2 3a3a3a3a3a3a3a3 1 1 7

// File: test/noc_mesh_tb.sv
// Testbench for the mesh NoC that replays the flit trace on the side pins and checks every exit
`default_nettype none

module noc_mesh_tb;
    import noc_pkg::*;

    localparam int    RESET_CYCLES = 8;
    localparam int    FIELDS       = 9;
    localparam int    MAX_LINES    = 32;
    localparam int    QUIET_CYCLES = 60;
    localparam int    PAYLOAD_W    = FLIT_W - 2 * COORD_W;
    localparam string TRACE_FILE   = "test/noc_mesh_trace.txt";
    // Trace columns
    localparam int F_IN_SIDE   = 0;
    localparam int F_IN_SEL    = 1;
    localparam int F_VC        = 2;
    localparam int F_DEST_X    = 3;
    localparam int F_DEST_Y    = 4;
    localparam int F_PAYLOAD   = 5;
    localparam int F_EXIT_SIDE = 6;
    localparam int F_EXIT_SEL  = 7;
    localparam int F_GROUP     = 8;

    logic        clk;
    logic        reset;
    serial_t     pin_in  [4];
    logic [1:0]  pin_sel [4];
    serial_t     pin_out [4];
    logic [63:0] trace_mem [FIELDS*MAX_LINES];
    logic [31:0] lcg_state = 32'd28436;
    int          num_lines;
    int          num_groups;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    bit          group_active = 1'b0;
    int          flits_checked = 0;
    int          visible_total = 0;

    // Expected flits of the running group
    logic [FLIT_W-1:0] exp_flit [MAX_LINES];
    logic [VC_W-1:0]   exp_vc   [MAX_LINES];
    int                exp_side [MAX_LINES];
    bit                exp_open [MAX_LINES];
    int                exp_count;
    int                open_count;

    // Pin collectors, one per side
    logic [FLIT_W-1:0] col_shift [4];
    logic [VC_W-1:0]   col_vc    [4];
    int                col_count [4] = '{0, 0, 0, 0};

    noc_mesh noc_mesh_inst (
        .clk       (clk),
        .reset     (reset),
        .west_in   (pin_in[DIR_WEST]),
        .south_in  (pin_in[DIR_SOUTH]),
        .east_in   (pin_in[DIR_EAST]),
        .north_in  (pin_in[DIR_NORTH]),
        .west_sel  (pin_sel[DIR_WEST]),
        .south_sel (pin_sel[DIR_SOUTH]),
        .east_sel  (pin_sel[DIR_EAST]),
        .north_sel (pin_sel[DIR_NORTH]),
        .west_out  (pin_out[DIR_WEST]),
        .south_out (pin_out[DIR_SOUTH]),
        .east_out  (pin_out[DIR_EAST]),
        .north_out (pin_out[DIR_NORTH])
    );

    bind mesh_router noc_mesh_assert router_checks (
        .clk     (clk),
        .reset   (reset),
        .link_n  (out_link[0]),
        .link_e  (out_link[1]),
        .link_s  (out_link[2]),
        .link_w  (out_link[3]),
        .full    (out_full),
        .request (4'b0000),
        .grant   (4'b0000)
    );

    bind port_arbiter noc_mesh_assert arbiter_checks (
        .clk     (clk),
        .reset   (reset),
        .link_n  ('0),
        .link_e  ('0),
        .link_s  ('0),
        .link_w  ('0),
        .full    (4'b0000),
        .request (request),
        .grant   (grant)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [71:0] got,
                                   input logic [71:0] expected);
        $display("FAIL time %0t %s got %h expected %h", $time, name, got, expected);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic string side_name(input int s);
        case (s)
            0: return "north";
            1: return "east";
            2: return "south";
            default: return "west";
        endcase
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [63:0] field(input int line, input int col);
        return trace_mem[line*FIELDS + col];
    endfunction

    // Idle pins carry random junk with valid low
    task automatic fill_idle();
        for (int s = 0; s < 4; s++) begin
            lcg_state = lcg_next(lcg_state);
            pin_in[s].valid  = 1'b0;
            pin_in[s].vc     = lcg_state[23:22];
            pin_in[s].nibble = lcg_state[19:16];
        end
    endtask

    task automatic load_trace();
        for (int i = 0; i < FIELDS*MAX_LINES; i++)
            trace_mem[i] = '1;
        $readmemh(TRACE_FILE, trace_mem);
        num_lines  = 0;
        num_groups = 0;
        while (num_lines < MAX_LINES && trace_mem[num_lines*FIELDS] != '1) begin
            if (num_lines == 0 || field(num_lines, F_GROUP) != field(num_lines - 1, F_GROUP))
                num_groups++;
            num_lines++;
        end
        assert (num_lines > 0) else report_problem("The trace file holds no flits");
    endtask

    // Completed burst must match an open expected flit on that side in any order
    task automatic match_flit(input int s);
        int hit;
        int first_open;
        hit        = -1;
        first_open = -1;
        for (int i = 0; i < exp_count; i++) begin
            if (exp_open[i] && exp_side[i] == s) begin
                if (first_open < 0)
                    first_open = i;
                if (hit < 0 && exp_flit[i] == col_shift[s] && exp_vc[i] == col_vc[s])
                    hit = i;
            end
        end
        assert (first_open >= 0) else report_problem($sformatf(
            "Unexpected flit %h arrived on the %s pins", col_shift[s], side_name(s)));
        assert (hit >= 0) else report_mismatch({side_name(s), "_out flit"},
            {col_vc[s], col_shift[s]}, {exp_vc[first_open], exp_flit[first_open]});
        exp_open[hit] = 1'b0;
        open_count--;
        flits_checked++;
    endtask

    // ======================================================================
    // Pin collectors and timeout
    // ======================================================================
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
            report_problem($sformatf("Timeout after %0d cycles waiting for flits", cycle_count));
        for (int s = 0; s < 4; s++) begin
            if (reset || !group_active) begin
                // Pin state is unknown until the first reset edge
                if (cycle_count > 1) begin
                    assert (!pin_out[s].valid)
                    else report_mismatch({side_name(s), "_out.valid"},
                                         72'(pin_out[s].valid), 72'(0));
                end
            end else if (pin_out[s].valid) begin
                if (col_count[s] > 0) begin
                    assert (pin_out[s].vc == col_vc[s])
                    else report_mismatch({side_name(s), "_out.vc"}, 72'(pin_out[s].vc),
                                         72'(col_vc[s]));
                end
                col_shift[s] = {col_shift[s][FLIT_W-NIBBLE_W-1:0], pin_out[s].nibble};
                col_vc[s]    = pin_out[s].vc;
                col_count[s] = col_count[s] + 1;
                if (col_count[s] == NIBBLES_PER_FLIT) begin
                    match_flit(s);
                    col_count[s] = 0;
                end
            end else begin
                assert (col_count[s] == 0) else report_problem($sformatf(
                    "Burst on the %s pins broke off after %0d nibbles", side_name(s),
                    col_count[s]));
            end
        end
    end

    // ======================================================================
    // Trace groups
    // ======================================================================
    task automatic run_group(input int first, input int last);
        int n;
        int in_side;
        int out_side;
        int port;
        @(negedge clk);
        group_active = 1'b1;
        exp_count    = 0;
        open_count   = 0;
        for (int s = 0; s < 4; s++)
            pin_sel[s] = 2'd3;
        for (int i = first; i < last; i++) begin
            n        = i - first;
            in_side  = int'(field(i, F_IN_SIDE));
            out_side = int'(field(i, F_EXIT_SIDE));
            pin_sel[in_side]  = 2'(field(i, F_IN_SEL));
            pin_sel[out_side] = 2'(field(i, F_EXIT_SEL));
            exp_flit[n] = {COORD_W'(field(i, F_DEST_X)), COORD_W'(field(i, F_DEST_Y)),
                           PAYLOAD_W'(field(i, F_PAYLOAD))};
            exp_vc[n]   = VC_W'(field(i, F_VC));
            exp_side[n] = out_side;
            // North and south ports count along x, east and west along y
            if (out_side == DIR_NORTH || out_side == DIR_SOUTH)
                port = int'(field(i, F_DEST_X)) - 1;
            else
                port = int'(field(i, F_DEST_Y)) - 1;
            // Seen at the pins only when the side selects the exit port
            exp_open[n] = (port == int'(field(i, F_EXIT_SEL)));
            if (exp_open[n]) begin
                open_count++;
                visible_total++;
            end
            exp_count++;
        end
        for (int k = 0; k < NIBBLES_PER_FLIT; k++) begin
            fill_idle();
            for (int i = first; i < last; i++) begin
                in_side = int'(field(i, F_IN_SIDE));
                pin_in[in_side].valid  = 1'b1;
                pin_in[in_side].vc     = VC_W'(field(i, F_VC));
                pin_in[in_side].nibble = exp_flit[i-first][FLIT_W-1-NIBBLE_W*k -: NIBBLE_W];
            end
            @(negedge clk);
        end
        fill_idle();
        while (open_count > 0) begin
            @(negedge clk);
            fill_idle();
        end
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            fill_idle();
        end
        for (int s = 0; s < 4; s++)
            assert (col_count[s] == 0) else report_problem($sformatf(
                "Partial burst left on the %s pins at the end of a group", side_name(s)));
        group_active = 1'b0;
    endtask

    initial begin
        int line;
        int stop;
        reset = 1'b1;
        for (int s = 0; s < 4; s++) begin
            pin_in[s]  = '0;
            pin_sel[s] = 2'd0;
        end
        load_trace();
        cycle_limit = 200 * num_groups + 100;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            fill_idle();
        end
        reset = 1'b0;
        // Quiet pins after reset
        repeat (10) begin
            @(negedge clk);
            fill_idle();
        end
        line = 0;
        while (line < num_lines) begin
            stop = line;
            while (stop < num_lines && field(stop, F_GROUP) == field(line, F_GROUP))
                stop++;
            run_group(line, stop);
            line = stop;
        end
        if (flits_checked == visible_total && flits_checked > 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            report_problem($sformatf("Only %0d of %0d expected flits were checked",
                                     flits_checked, visible_total));
        end
    end

endmodule

`default_nettype wire

// File: test/noc_mesh_assert.sv
// Concurrent checks on router output holding and arbiter grants, attached by bind from the testbench
`default_nettype none

module noc_mesh_assert (
    input  logic            clk,
    input  logic            reset,
    input  noc_pkg::link_t  link_n,
    input  noc_pkg::link_t  link_e,
    input  noc_pkg::link_t  link_s,
    input  noc_pkg::link_t  link_w,
    input  logic [3:0]      full,
    input  logic [3:0]      request,
    input  logic [3:0]      grant
);
    import noc_pkg::*;

    link_t links [4];

    assign links[DIR_NORTH] = link_n;
    assign links[DIR_EAST]  = link_e;
    assign links[DIR_SOUTH] = link_s;
    assign links[DIR_WEST]  = link_w;

    // Output register frozen while downstream is full
    for (genvar d = 0; d < 4; d++) begin : g_hold
        hold_under_full: assert property (@(posedge clk) disable iff (reset)
            links[d].valid && full[d] |=> $stable(links[d]))
        else $error("Router output %0d changed while downstream was full", d);
    end

    grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
    else $error("Arbiter granted more than one requester");

    grant_requested: assert property (@(posedge clk) disable iff (reset)
        (grant & ~request) == 4'b0000)
    else $error("Arbiter granted an input that was not requesting");

endmodule

`default_nettype wire

// File: src/noc_mesh.sv
// Top level of the 3x3 mesh NoC, instance this with the four 4-bit side pin groups
`default_nettype none

module noc_mesh (
    input  logic              clk,
    input  logic              reset,
    input  noc_pkg::serial_t  west_in,
    input  noc_pkg::serial_t  south_in,
    input  noc_pkg::serial_t  east_in,
    input  noc_pkg::serial_t  north_in,
    input  logic [1:0]        west_sel,
    input  logic [1:0]        south_sel,
    input  logic [1:0]        east_sel,
    input  logic [1:0]        north_sel,
    output noc_pkg::serial_t  west_out,
    output noc_pkg::serial_t  south_out,
    output noc_pkg::serial_t  east_out,
    output noc_pkg::serial_t  north_out
);
    import noc_pkg::*;

    localparam int ROUTER_BUFFER_DEPTH = 2;

    // Per-side pin groups, indexed by dir_e
    serial_t    side_in  [4];
    logic [1:0] side_sel [4];
    serial_t    side_out [4];

    // Edge side ports, indexed [side][port]
    link_t                 side_to_mesh   [4][MESH_DIM];
    link_t                 side_from_mesh [4][MESH_DIM];
    logic [MESH_DIM-1:0]   side_full      [4];

    // Router ports, indexed [x-1][y-1][dir]
    link_t      r_in       [MESH_DIM][MESH_DIM][4];
    link_t      r_out      [MESH_DIM][MESH_DIM][4];
    logic [3:0] r_in_full  [MESH_DIM][MESH_DIM];
    logic [3:0] r_out_full [MESH_DIM][MESH_DIM];

    assign side_in[DIR_NORTH]  = north_in;
    assign side_in[DIR_EAST]   = east_in;
    assign side_in[DIR_SOUTH]  = south_in;
    assign side_in[DIR_WEST]   = west_in;
    assign side_sel[DIR_NORTH] = north_sel;
    assign side_sel[DIR_EAST]  = east_sel;
    assign side_sel[DIR_SOUTH] = south_sel;
    assign side_sel[DIR_WEST]  = west_sel;
    assign north_out = side_out[DIR_NORTH];
    assign east_out  = side_out[DIR_EAST];
    assign south_out = side_out[DIR_SOUTH];
    assign west_out  = side_out[DIR_WEST];

    // ======================================================================
    // Edge sides
    // ======================================================================
    for (genvar gs = 0; gs < 4; gs++) begin : g_side
        mesh_edge_side #(.SIDE(dir_e'(gs))) side_inst (
            .clk            (clk),
            .reset          (reset),
            .serial_in      (side_in[gs]),
            .sel            (side_sel[gs]),
            .serial_out     (side_out[gs]),
            .to_mesh        (side_to_mesh[gs]),
            .from_mesh      (side_from_mesh[gs]),
            .from_mesh_full (side_full[gs])
        );
    end

    // ======================================================================
    // Routers and mesh links
    // ======================================================================
    for (genvar gx = 0; gx < MESH_DIM; gx++) begin : g_col
        for (genvar gy = 0; gy < MESH_DIM; gy++) begin : g_row
            mesh_router #(
                .ROUTER_X     (gx + 1),
                .ROUTER_Y     (gy + 1),
                .BUFFER_DEPTH (ROUTER_BUFFER_DEPTH)
            ) router_inst (
                .clk      (clk),
                .reset    (reset),
                .in_link  (r_in[gx][gy]),
                .in_full  (r_in_full[gx][gy]),
                .out_link (r_out[gx][gy]),
                .out_full (r_out_full[gx][gy])
            );

            for (genvar gd = 0; gd < 4; gd++) begin : g_dir
                // Neighbour in direction gd, off the grid means an edge port
                localparam int NX = gx + int'(gd == DIR_EAST) - int'(gd == DIR_WEST);
                localparam int NY = gy + int'(gd == DIR_NORTH) - int'(gd == DIR_SOUTH);
                localparam int PORT = (gd == DIR_NORTH || gd == DIR_SOUTH) ? gx : gy;

                if (NX < 0 || NX >= MESH_DIM || NY < 0 || NY >= MESH_DIM) begin : g_edge
                    assign r_in[gx][gy][gd]            = side_to_mesh[gd][PORT];
                    assign side_from_mesh[gd][PORT]    = r_out[gx][gy][gd];
                    assign r_out_full[gx][gy][gd]      = side_full[gd][PORT];
                end else begin : g_link
                    // Opposite port of the neighbour is gd ^ 2
                    assign r_in[gx][gy][gd]       = r_out[NX][NY][gd ^ 2];
                    assign r_out_full[gx][gy][gd] = r_in_full[NX][NY][gd ^ 2];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/mesh_edge_side.sv
// One mesh side that steers its pin group to one of three edge ports chosen by sel
`default_nettype none

module mesh_edge_side #(
    parameter noc_pkg::dir_e SIDE = noc_pkg::DIR_NORTH
) (
    input  logic                          clk,
    input  logic                          reset,
    input  noc_pkg::serial_t              serial_in,
    input  logic [1:0]                    sel,
    output noc_pkg::serial_t              serial_out,
    output noc_pkg::link_t                to_mesh   [noc_pkg::MESH_DIM],
    input  noc_pkg::link_t                from_mesh [noc_pkg::MESH_DIM],
    output logic [noc_pkg::MESH_DIM-1:0]  from_mesh_full
);
    import noc_pkg::*;

    serial_t ser_out [MESH_DIM];

    for (genvar p = 0; p < MESH_DIM; p++) begin : g_port
        serial_t port_in;

        // Only the selected deserializer sees valid nibbles
        always_comb begin
            port_in       = serial_in;
            port_in.valid = serial_in.valid && (sel == 2'(p));
        end

        flit_deserializer deser_inst (
            .clk       (clk),
            .reset     (reset),
            .serial_in (port_in),
            .flit_out  (to_mesh[p])
        );

        // Keeps shifting even when not selected
        flit_serializer ser_inst (
            .clk        (clk),
            .reset      (reset),
            .flit_in    (from_mesh[p]),
            .full       (from_mesh_full[p]),
            .serial_out (ser_out[p])
        );
    end

    // Pin mux with sel 3 leaving the pins idle
    always_comb begin
        serial_out = '0;
        if (sel < 2'(MESH_DIM))
            serial_out = ser_out[sel];
    end

endmodule

`default_nettype wire

// File: src/mesh_router.sv
// Mesh router with XY routing, input FIFOs and one arbitrated register per output port
`default_nettype none

module mesh_router #(
    parameter int ROUTER_X     = 1,
    parameter int ROUTER_Y     = 1,
    parameter int BUFFER_DEPTH = 2
) (
    input  logic            clk,
    input  logic            reset,
    input  noc_pkg::link_t  in_link  [4],
    output logic [3:0]      in_full,
    output noc_pkg::link_t  out_link [4],
    input  logic [3:0]      out_full
);
    import noc_pkg::*;

    localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

    link_t      head       [4];
    logic [3:0] head_valid;
    logic [3:0] pop;
    logic [3:0] ready;
    // Indexed [output][input]
    logic [3:0] request    [4];
    logic [3:0] grant      [4];

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // XY routing, then the edge exit once the column and row match
    function automatic dir_e route(input flit_hdr_t hdr);
        logic [COORD_W-1:0] cx;
        logic [COORD_W-1:0] cy;
        cx = hdr.dest_x;
        cy = hdr.dest_y;
        if (cx < COORD_W'(1))
            cx = COORD_W'(1);
        if (cx > COORD_W'(MESH_DIM))
            cx = COORD_W'(MESH_DIM);
        if (cy < COORD_W'(1))
            cy = COORD_W'(1);
        if (cy > COORD_W'(MESH_DIM))
            cy = COORD_W'(MESH_DIM);
        if (cx > ROUTER_X)
            return DIR_EAST;
        if (cx < ROUTER_X)
            return DIR_WEST;
        if (cy > ROUTER_Y)
            return DIR_NORTH;
        if (cy < ROUTER_Y)
            return DIR_SOUTH;
        if (hdr.dest_x == '0)
            return DIR_WEST;
        if (hdr.dest_x == COORD_W'(MESH_DIM + 1))
            return DIR_EAST;
        if (hdr.dest_y == '0)
            return DIR_SOUTH;
        return DIR_NORTH;
    endfunction

    // ======================================================================
    // Input FIFOs
    // ======================================================================
    for (genvar i = 0; i < 4; i++) begin : g_in
        link_t            mem [BUFFER_DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;
        logic             push;

        assign in_full[i]    = (count == CNT_W'(BUFFER_DEPTH));
        assign push          = in_link[i].valid && !in_full[i];
        assign head[i]       = mem[rd_ptr];
        assign head_valid[i] = (count != '0);

        always_ff @(posedge clk) begin
            if (reset) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push)
                    wr_ptr <= next_ptr(wr_ptr);
                if (pop[i])
                    rd_ptr <= next_ptr(rd_ptr);
                count <= count + CNT_W'(push) - CNT_W'(pop[i]);
            end
        end

        always_ff @(posedge clk) begin
            if (push)
                mem[wr_ptr] <= in_link[i];
        end
    end

    // Each FIFO head asks for exactly one output
    always_comb begin
        dir_e dir;
        for (int i = 0; i < 4; i++) begin
            dir = route(head[i].flit.hdr);
            for (int d = 0; d < 4; d++)
                request[d][i] = head_valid[i] && (dir == dir_e'(d));
        end
    end

    always_comb begin
        pop = '0;
        for (int d = 0; d < 4; d++)
            for (int i = 0; i < 4; i++)
                if (grant[d][i] && ready[d])
                    pop[i] = 1'b1;
    end

    // ======================================================================
    // Output ports
    // ======================================================================
    for (genvar d = 0; d < 4; d++) begin : g_out
        link_t           pick;
        logic            valid_q;
        logic [VC_W-1:0] vc_q;
        flit_u           flit_q;

        // Register is free when empty or being drained downstream
        assign ready[d] = !valid_q || !out_full[d];

        port_arbiter arb_inst (
            .clk     (clk),
            .reset   (reset),
            .request (request[d]),
            .advance (ready[d]),
            .grant   (grant[d])
        );

        always_comb begin
            pick = '0;
            for (int i = 0; i < 4; i++)
                if (grant[d][i])
                    pick = head[i];
        end

        always_ff @(posedge clk) begin
            if (reset)
                valid_q <= 1'b0;
            else if (ready[d])
                valid_q <= |grant[d];
        end

        always_ff @(posedge clk) begin
            if (ready[d] && |grant[d]) begin
                vc_q   <= pick.vc;
                flit_q <= pick.flit;
            end
        end

        assign out_link[d] = {valid_q, vc_q, flit_q};
    end

endmodule

`default_nettype wire

// File: src/flit_serializer.sv
// Edge outbound stage, sends one router flit as 16 pin nibbles, busy acts as link full
`default_nettype none

module flit_serializer (
    input  logic              clk,
    input  logic              reset,
    input  noc_pkg::link_t    flit_in,
    output logic              full,
    output noc_pkg::serial_t  serial_out
);
    import noc_pkg::*;

    localparam int CNT_W = $clog2(NIBBLES_PER_FLIT);

    logic              busy;
    logic              accept;
    logic [CNT_W-1:0]  count;
    logic [FLIT_W-1:0] shift_q;
    logic [VC_W-1:0]   vc_q;

    assign accept = flit_in.valid && !busy;

    // ======================================================================
    // Burst control
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (accept) begin
            busy  <= 1'b1;
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
            // Last of 16 nibbles on the pins
            if (count == CNT_W'(NIBBLES_PER_FLIT - 1))
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= flit_in.flit.raw;
            vc_q    <= flit_in.vc;
        end else if (busy) begin
            shift_q <= shift_q << NIBBLE_W;
        end
    end

    assign full       = busy;
    assign serial_out = {busy, vc_q, shift_q[FLIT_W-1 -: NIBBLE_W]};

endmodule

`default_nettype wire

// File: src/flit_deserializer.sv
// Edge inbound stage, gathers 16 pin nibbles into one flit for the edge router
`default_nettype none

module flit_deserializer (
    input  logic              clk,
    input  logic              reset,
    input  noc_pkg::serial_t  serial_in,
    output noc_pkg::link_t    flit_out
);
    import noc_pkg::*;

    localparam int CNT_W = $clog2(NIBBLES_PER_FLIT);

    logic [CNT_W-1:0]  count;
    logic              last_nibble;
    logic              valid_q;
    logic [FLIT_W-1:0] shift_q;
    logic [VC_W-1:0]   vc_q;

    assign last_nibble = (count == CNT_W'(NIBBLES_PER_FLIT - 1));

    // Count wraps after the 16th nibble
    always_ff @(posedge clk) begin
        if (reset) begin
            count   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= serial_in.valid && last_nibble;
            if (serial_in.valid)
                count <= count + 1'b1;
        end
    end

    // Most significant nibble arrives first
    always_ff @(posedge clk) begin
        if (serial_in.valid) begin
            shift_q <= {shift_q[FLIT_W-NIBBLE_W-1:0], serial_in.nibble};
            if (last_nibble)
                vc_q <= serial_in.vc;
        end
    end

    assign flit_out = {valid_q, vc_q, shift_q};

endmodule

`default_nettype wire

// File: src/port_arbiter.sv
// Round-robin arbiter giving one router output port to one of four input FIFOs
`default_nettype none

module port_arbiter (
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] request,
    input  logic       advance,
    output logic [3:0] grant
);
    import noc_pkg::*;

    // Highest priority requester
    logic [1:0] ptr;
    logic [1:0] grant_idx;
    logic       found;

    // Search starts at the pointer and wraps around
    always_comb begin
        logic [1:0] idx;
        grant     = '0;
        grant_idx = ptr;
        found     = 1'b0;
        for (int i = 0; i < 4; i++) begin
            idx = ptr + 2'(i);
            if (!found && request[idx]) begin
                grant[idx] = 1'b1;
                grant_idx  = idx;
                found      = 1'b1;
            end
        end
    end

    // Pointer moves past the winner only when its flit is taken
    always_ff @(posedge clk) begin
        if (reset)
            ptr <= 2'(DIR_NORTH);
        else if (advance && found)
            ptr <= grant_idx + 2'd1;
    end

endmodule

`default_nettype wire

// File: src/noc_pkg.sv
// Shared flit, link and pin types plus mesh constants, imported by every NoC RTL block
`default_nettype none

package noc_pkg;

    // ======================================================================
    // Mesh geometry and widths
    // ======================================================================
    localparam int FLIT_W           = 64;
    localparam int NIBBLE_W         = 4;
    localparam int NIBBLES_PER_FLIT = 16;
    localparam int VC_W             = 2;
    // Coordinates 0..4, where 0 and 4 are the edge ports
    localparam int COORD_W          = 3;
    localparam int MESH_DIM         = 3;

    // Router port order, also used to number the mesh sides
    typedef enum logic [1:0] {
        DIR_NORTH = 2'd0,
        DIR_EAST  = 2'd1,
        DIR_SOUTH = 2'd2,
        DIR_WEST  = 2'd3
    } dir_e;

    // Header view, destination in the top bits
    typedef struct packed {
        logic [COORD_W-1:0]          dest_x;
        logic [COORD_W-1:0]          dest_y;
        logic [FLIT_W-2*COORD_W-1:0] payload;
    } flit_hdr_t;

    // Raw view is filled by the deserializer, header view is decoded by routers
    typedef union packed {
        logic [FLIT_W-1:0] raw;
        flit_hdr_t         hdr;
    } flit_u;

    // One mesh link direction
    typedef struct packed {
        logic            valid;
        logic [VC_W-1:0] vc;
        flit_u           flit;
    } link_t;

    // One external pin group
    typedef struct packed {
        logic                valid;
        logic [VC_W-1:0]     vc;
        logic [NIBBLE_W-1:0] nibble;
    } serial_t;

endpackage

`default_nettype wire
